// ==== Bender.yml ====
package:
  name: cpl_inbound

sources:
  - include_dirs:
      - include
    files:
      - rtl/cpl_pkg.sv
      - rtl/cpl_fifo.sv
      - rtl/cpl_tlp_gen.sv
      - rtl/cpl_inbound_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_clkgen.sv
      - tests/tb_cpl_inbound.sv

// ==== include/cpl_defs.svh ====
`ifndef CPL_DEFS_SVH
`define CPL_DEFS_SVH

// ID FIFO, one entry per outstanding non-posted request
`define CPL_ID_DEPTH        16

// Free entries at or below which rx_np_ok drops
`define CPL_ID_ALMOST_FULL  4

// Output beat buffer
`define CPL_TLP_DEPTH       16

`endif

// ==== rtl/cpl_fifo.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpl_fifo #(
    parameter type T           = logic [31:0],
    parameter int  DEPTH       = 16,
    parameter int  ALMOST_FULL = 1
) (
    input  logic clk,
    input  logic rst,

    input  logic wr_valid,
    input  T     wr_data,
    output logic wr_ready,
    output logic almost_full,

    output logic rd_valid,
    output T     rd_data,
    input  logic rd_ready
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [CW-1:0] count_next;
    logic [CW-1:0] mem_count;
    logic          push;
    logic          pop;
    logic          out_free;
    logic          bypass;
    logic          load_mem;

    // Count covers the memory and the output register
    assign wr_ready   = (count != CW'(DEPTH));
    assign push       = wr_valid && wr_ready;
    assign pop        = rd_valid && rd_ready;
    assign mem_count  = count - CW'(rd_valid);
    assign out_free   = !rd_valid || rd_ready;

    // Empty memory lets a write go straight to the output register
    assign bypass     = push && out_free && (mem_count == '0);
    assign load_mem   = out_free && (mem_count != '0);

    assign count_next = count + CW'(push) - CW'(pop);

    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
        if (ptr == AW'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            rd_valid    <= 1'b0;
            almost_full <= 1'b0;
        end else begin
            count       <= count_next;
            almost_full <= (CW'(DEPTH) - count_next) <= CW'(ALMOST_FULL);
            if (push && !bypass) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (load_mem) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (bypass || load_mem) begin
                rd_valid <= 1'b1;
            end else if (pop) begin
                rd_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push && !bypass) begin
            mem[wr_ptr] <= wr_data;
        end
        if (load_mem) begin
            rd_data <= mem[rd_ptr];
        end else if (bypass) begin
            rd_data <= wr_data;
        end
    end

    // A full FIFO refuses writes and must have its output register loaded
    a_no_write_when_full: assert property (
        @(posedge clk) disable iff (rst)
        !wr_ready |-> rd_valid
    );

    a_count_bound: assert property (
        @(posedge clk) disable iff (rst)
        count <= CW'(DEPTH)
    );

endmodule

`default_nettype wire

// ==== rtl/cpl_inbound_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpl_defs.svh"

module cpl_inbound_top import cpl_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    output logic        rx_np_ok,

    // ID entries from the request decoder
    input  logic        tlp_id_valid,
    input  logic        tlp_id_write,
    input  logic [28:0] tlp_id_data,
    output logic        tlp_id_ready,

    input  logic        wr_h_valid,
    input  logic [1:0]  wr_h_resp,
    output logic        wr_h_ready,

    input  logic        rd_h_valid,
    input  logic [6:0]  rd_h_addr,
    input  logic [9:0]  rd_h_len,
    input  logic [11:0] rd_h_bytes,
    input  logic        rd_h_last,
    input  logic [1:0]  rd_h_resp,
    output logic        rd_h_ready,

    input  logic        rd_d_valid,
    input  logic [31:0] rd_d_data,
    input  logic        rd_d_last,
    output logic        rd_d_ready,

    // Completion TLP stream
    output logic        tx_valid,
    output logic [31:0] tx_data,
    output logic        tx_last,
    output logic        tx_error,
    input  logic        tx_ready,

    input  logic [7:0]  bus_number,
    input  logic [4:0]  dev_number,
    input  logic [2:0]  func_number
);

    cpl_id_t   tlp_id_in;
    cpl_id_t   id_entry;
    logic      id_valid;
    logic      id_ready;
    logic      id_almost_full;

    cpl_beat_t beat;
    logic      beat_valid;
    logic      beat_ready;
    cpl_beat_t tx_beat;

    assign tlp_id_in = {tlp_id_write, tlp_id_data};
    assign rx_np_ok  = !id_almost_full;

    cpl_fifo #(
        .T           (cpl_id_t),
        .DEPTH       (`CPL_ID_DEPTH),
        .ALMOST_FULL (`CPL_ID_ALMOST_FULL)
    ) id_fifo (
        .clk         (clk),
        .rst         (rst),
        .wr_valid    (tlp_id_valid),
        .wr_data     (tlp_id_in),
        .wr_ready    (tlp_id_ready),
        .almost_full (id_almost_full),
        .rd_valid    (id_valid),
        .rd_data     (id_entry),
        .rd_ready    (id_ready)
    );

    cpl_tlp_gen tlp_gen (
        .clk         (clk),
        .rst         (rst),
        .id_valid    (id_valid),
        .id_entry    (id_entry),
        .id_ready    (id_ready),
        .wr_h_valid  (wr_h_valid),
        .wr_h_resp   (cpl_resp_t'(wr_h_resp)),
        .wr_h_ready  (wr_h_ready),
        .rd_h_valid  (rd_h_valid),
        .rd_h_addr   (rd_h_addr),
        .rd_h_len    (rd_h_len),
        .rd_h_bytes  (rd_h_bytes),
        .rd_h_last   (rd_h_last),
        .rd_h_resp   (cpl_resp_t'(rd_h_resp)),
        .rd_h_ready  (rd_h_ready),
        .rd_d_valid  (rd_d_valid),
        .rd_d_data   (rd_d_data),
        .rd_d_last   (rd_d_last),
        .rd_d_ready  (rd_d_ready),
        .beat_valid  (beat_valid),
        .beat        (beat),
        .beat_ready  (beat_ready),
        .bus_number  (bus_number),
        .dev_number  (dev_number),
        .func_number (func_number)
    );

    cpl_fifo #(
        .T           (cpl_beat_t),
        .DEPTH       (`CPL_TLP_DEPTH)
    ) tlp_fifo (
        .clk         (clk),
        .rst         (rst),
        .wr_valid    (beat_valid),
        .wr_data     (beat),
        .wr_ready    (beat_ready),
        .almost_full (),
        .rd_valid    (tx_valid),
        .rd_data     (tx_beat),
        .rd_ready    (tx_ready)
    );

    assign tx_data  = tx_beat.data;
    assign tx_last  = tx_beat.last;
    assign tx_error = tx_beat.error;

endmodule

`default_nettype wire

// ==== rtl/cpl_pkg.sv ====
`default_nettype none

package cpl_pkg;

    // Local bus response code
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } cpl_resp_t;

    // One entry per non-posted request
    typedef struct packed {
        logic        write;
        logic [2:0]  tc;
        logic [1:0]  attr;
        logic [15:0] reqid;
        logic [7:0]  tag;
    } cpl_id_t;

    // Output stream beat
    typedef struct packed {
        logic        error;
        logic        last;
        logic [31:0] data;
    } cpl_beat_t;

    // Fmt/type field of a 3DW completion
    localparam logic [4:0] CPL_FMT_TYPE  = 5'b01010;

    // Completion status
    localparam logic [2:0] CPL_STATUS_SC = 3'b000;
    localparam logic [2:0] CPL_STATUS_UR = 3'b001;

endpackage

`default_nettype wire

// ==== rtl/cpl_tlp_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpl_tlp_gen import cpl_pkg::*; (
    input  logic        clk,
    input  logic        rst,

    input  logic        id_valid,
    input  cpl_id_t     id_entry,
    output logic        id_ready,

    input  logic        wr_h_valid,
    input  cpl_resp_t   wr_h_resp,
    output logic        wr_h_ready,

    input  logic        rd_h_valid,
    input  logic [6:0]  rd_h_addr,
    input  logic [9:0]  rd_h_len,
    input  logic [11:0] rd_h_bytes,
    input  logic        rd_h_last,
    input  cpl_resp_t   rd_h_resp,
    output logic        rd_h_ready,

    input  logic        rd_d_valid,
    input  logic [31:0] rd_d_data,
    input  logic        rd_d_last,
    output logic        rd_d_ready,

    output logic        beat_valid,
    output cpl_beat_t   beat,
    input  logic        beat_ready,

    input  logic [7:0]  bus_number,
    input  logic [4:0]  dev_number,
    input  logic [2:0]  func_number
);

    typedef enum logic [2:0] {
        ST_H0,
        ST_H1,
        ST_H2,
        ST_DATA,
        ST_FLUSH_D,
        ST_FLUSH_H
    } state_t;

    state_t      state;
    state_t      next_state;

    logic        h_write;
    logic        h_valid;
    logic        h_ready;
    logic        h_err;
    logic        h_last;
    logic [6:0]  h_addr;
    logic [9:0]  h_len;
    logic [11:0] h_bytes;
    logic        flush_err;

    // Head ID entry picks the header source
    assign h_write    = id_entry.write;
    assign h_valid    = id_valid && (h_write ? wr_h_valid : rd_h_valid);
    assign wr_h_ready = id_valid && h_write && h_ready;
    assign rd_h_ready = id_valid && !h_write && h_ready;
    assign id_ready   = h_ready && h_valid && h_last;

    always_comb begin
        h_addr  = 7'd0;
        h_len   = 10'd1;
        h_bytes = 12'd4;
        h_last  = 1'b1;
        if (h_write) begin
            h_err = (wr_h_resp != OKAY);
        end else begin
            // Later parts of a failed read stay UR
            h_err   = flush_err || (rd_h_resp != OKAY);
            h_addr  = rd_h_addr;
            h_len   = rd_h_len;
            h_bytes = rd_h_bytes;
            h_last  = rd_h_last;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_H0;
            flush_err <= 1'b0;
        end else begin
            state <= next_state;
            if (state == ST_FLUSH_D && next_state != ST_FLUSH_D) begin
                flush_err <= (next_state == ST_FLUSH_H);
            end
        end
    end

    always_comb begin
        next_state = state;
        h_ready    = 1'b0;
        rd_d_ready = 1'b0;
        beat_valid = 1'b0;
        beat       = '0;

        case (state)
            ST_H0: begin
                beat.data[30]    = !h_write && !h_err;
                beat.data[28:24] = CPL_FMT_TYPE;
                beat.data[22:20] = id_entry.tc;
                beat.data[13:12] = id_entry.attr;
                beat.data[9:0]   = h_len;
                beat.error       = h_err;
                beat_valid       = h_valid;
                if (h_valid && beat_ready) begin
                    next_state = ST_H1;
                end
            end
            ST_H1: begin
                beat.data[31:16] = {bus_number, dev_number, func_number};
                beat.data[15:13] = h_err ? CPL_STATUS_UR : CPL_STATUS_SC;
                beat.data[11:0]  = h_bytes;
                beat.error       = h_err;
                beat_valid       = 1'b1;
                if (beat_ready) begin
                    next_state = ST_H2;
                end
            end
            ST_H2: begin
                beat.data[31:16] = id_entry.reqid;
                beat.data[15:8]  = id_entry.tag;
                beat.data[6:0]   = h_addr;
                beat.error       = h_err;
                beat.last        = h_write || h_err;
                beat_valid       = 1'b1;
                if (beat_ready) begin
                    if (h_write) begin
                        h_ready    = 1'b1;
                        next_state = ST_H0;
                    end else if (h_err) begin
                        // Header part stays until its data is drained
                        next_state = ST_FLUSH_D;
                    end else begin
                        h_ready    = 1'b1;
                        next_state = ST_DATA;
                    end
                end
            end
            ST_DATA: begin
                beat.data  = rd_d_data;
                beat.last  = rd_d_last;
                beat_valid = rd_d_valid;
                rd_d_ready = beat_ready;
                if (rd_d_valid && rd_d_last && beat_ready) begin
                    next_state = ST_H0;
                end
            end
            ST_FLUSH_D: begin
                rd_d_ready = 1'b1;
                if (rd_d_valid && rd_d_last) begin
                    h_ready    = 1'b1;
                    next_state = h_last ? ST_H0 : ST_FLUSH_H;
                end
            end
            ST_FLUSH_H: begin
                if (h_valid) begin
                    next_state = ST_H0;
                end
            end
            default: begin
                next_state = ST_H0;
            end
        endcase
    end

    a_state_legal: assert property (
        @(posedge clk) disable iff (rst)
        state inside {ST_H0, ST_H1, ST_H2, ST_DATA, ST_FLUSH_D, ST_FLUSH_H}
    );

    // A header part is only popped while its source still offers it
    a_one_header_ready: assert property (
        @(posedge clk) disable iff (rst)
        (wr_h_ready || rd_h_ready) |-> h_valid
    );

    // Stalled header beat holds until the output FIFO takes it
    a_header_hold: assert property (
        @(posedge clk) disable iff (rst)
        beat_valid && !beat_ready && (state inside {ST_H0, ST_H1, ST_H2})
        |=> $stable(beat)
    );

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
rtl/cpl_pkg.sv
rtl/cpl_fifo.sv
rtl/cpl_tlp_gen.sv
rtl/cpl_inbound_top.sv
tests/tb_clkgen.sv
tests/tb_cpl_inbound.sv

// ==== tests/tb_clkgen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = !clk;
    end

    // Reset held for four rising edges
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== tests/tb_cpl_inbound.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "cpl_defs.svh"

module tb_cpl_inbound import cpl_pkg::*; ();

    typedef struct packed {
        logic [6:0]  addr;
        logic [9:0]  len;
        logic [11:0] bytes;
        logic        last;
        logic [1:0]  resp;
    } rd_hdr_t;

    logic        clk;
    logic        rst;
    logic        rx_np_ok;
    logic        tlp_id_valid = 1'b0;
    logic        tlp_id_write = 1'b0;
    logic [28:0] tlp_id_data  = '0;
    logic        tlp_id_ready;
    logic        wr_h_valid   = 1'b0;
    logic [1:0]  wr_h_resp    = '0;
    logic        wr_h_ready;
    logic        rd_h_valid   = 1'b0;
    logic [6:0]  rd_h_addr    = '0;
    logic [9:0]  rd_h_len     = '0;
    logic [11:0] rd_h_bytes   = '0;
    logic        rd_h_last    = 1'b0;
    logic [1:0]  rd_h_resp    = '0;
    logic        rd_h_ready;
    logic        rd_d_valid   = 1'b0;
    logic [31:0] rd_d_data    = '0;
    logic        rd_d_last    = 1'b0;
    logic        rd_d_ready;
    logic        tx_valid;
    logic [31:0] tx_data;
    logic        tx_last;
    logic        tx_error;
    logic        tx_ready     = 1'b0;
    logic [7:0]  bus_number   = 8'h3a;
    logic [4:0]  dev_number   = 5'h11;
    logic [2:0]  func_number  = 3'h5;

    cpl_id_t     id_q[$];
    logic [1:0]  wr_h_q[$];
    rd_hdr_t     rd_h_q[$];
    logic [32:0] rd_d_q[$];
    cpl_beat_t   exp_q[$];
    cpl_beat_t   exp_head      = '0;
    logic        exp_avail     = 1'b0;
    cpl_beat_t   tx_beat_now;
    integer      seed          = 11941;
    string       cur_test      = "reset";
    int          errors        = 0;
    int          err_base      = 0;
    int          pass_count    = 0;
    int          fail_count    = 0;
    int          planned_beats = 0;
    int          cycles        = 0;
    int          id_accepted   = 0;
    int          id_base       = 0;
    logic        stall_en      = 1'b0;
    logic        fill_check    = 1'b0;

    tb_clkgen clkgen (
        .clk (clk),
        .rst (rst)
    );

    cpl_inbound_top dut0 (.*);

    assign tx_beat_now = {tx_error, tx_last, tx_data};

    // Source side of each stream, one queue entry per transfer
    always @(posedge clk) begin
        if (rst) begin
            tlp_id_valid <= 1'b0;
            wr_h_valid   <= 1'b0;
            rd_h_valid   <= 1'b0;
            rd_d_valid   <= 1'b0;
        end else begin
            if (tlp_id_valid && tlp_id_ready) begin
                id_accepted <= id_accepted + 1;
            end
            if (!tlp_id_valid || tlp_id_ready) begin
                tlp_id_valid <= id_q.size() > 0;
                if (id_q.size() > 0) begin
                    {tlp_id_write, tlp_id_data} <= id_q.pop_front();
                end
            end
            // Write headers withheld while the ID FIFO is being filled
            if (!wr_h_valid || wr_h_ready) begin
                wr_h_valid <= !fill_check && wr_h_q.size() > 0;
                if (!fill_check && wr_h_q.size() > 0) begin
                    wr_h_resp <= wr_h_q.pop_front();
                end
            end
            if (!rd_h_valid || rd_h_ready) begin
                rd_h_valid <= rd_h_q.size() > 0;
                if (rd_h_q.size() > 0) begin
                    {rd_h_addr, rd_h_len, rd_h_bytes, rd_h_last, rd_h_resp} <= rd_h_q.pop_front();
                end
            end
            if (!rd_d_valid || rd_d_ready) begin
                rd_d_valid <= rd_d_q.size() > 0;
                if (rd_d_q.size() > 0) begin
                    {rd_d_last, rd_d_data} <= rd_d_q.pop_front();
                end
            end
        end
    end

    always @(posedge clk) begin
        tx_ready <= !stall_en || (($random(seed) & 3) != 0);
    end

    always @(posedge clk) begin
        if (!rst && tx_valid && tx_ready && exp_q.size() > 0) begin
            void'(exp_q.pop_front());
        end
    end

    // Queue head copied at the falling edge, stable for the next check
    always @(negedge clk) begin
        exp_avail <= exp_q.size() > 0;
        if (exp_q.size() > 0) begin
            exp_head <= exp_q[0];
        end
    end

    a_tx_match: assert property (
        @(posedge clk) disable iff (rst)
        tx_valid && tx_ready && exp_avail |-> tx_beat_now == exp_head
    ) else begin
        $display("ERROR %s: expected %h actual %h", cur_test, exp_head, $sampled(tx_beat_now));
        errors++;
    end

    a_tx_expected: assert property (
        @(posedge clk) disable iff (rst)
        tx_valid && tx_ready |-> exp_avail
    ) else begin
        $display("%s: a completion beat came out with none outstanding", cur_test);
        errors++;
    end

    a_np_ok_level: assert property (
        @(posedge clk) disable iff (rst)
        fill_check |-> rx_np_ok == ((id_accepted - id_base) <
                                    (`CPL_ID_DEPTH - `CPL_ID_ALMOST_FULL))
    ) else begin
        $display("%s: rx_np_ok at the wrong level for the IDs held", cur_test);
        errors++;
    end

    a_id_ready_level: assert property (
        @(posedge clk) disable iff (rst)
        fill_check |-> tlp_id_ready == ((id_accepted - id_base) < `CPL_ID_DEPTH)
    ) else begin
        $display("%s: tlp_id_ready at the wrong level for the IDs held", cur_test);
        errors++;
    end

    task automatic push_expect(input cpl_beat_t b);
        exp_q.push_back(b);
        planned_beats++;
    endtask

    function automatic cpl_id_t rand_id(input logic write);
        cpl_id_t     id;
        logic [31:0] r;
        r        = $random(seed);
        id.write = write;
        id.tc    = r[2:0];
        id.attr  = r[4:3];
        id.tag   = r[12:5];
        r        = $random(seed);
        id.reqid = r[15:0];
        return id;
    endfunction

    // Three header beats of a 3DW completion
    task automatic expect_header(input cpl_id_t id, input logic err, input logic [9:0] len,
                                 input logic [11:0] bytes, input logic [6:0] addr,
                                 input logic write);
        cpl_beat_t b;
        b.error = err;
        b.last  = 1'b0;
        b.data  = {1'b0, !write && !err, 1'b0, CPL_FMT_TYPE, 1'b0, id.tc, 6'd0, id.attr,
                   2'd0, len};
        push_expect(b);
        b.data  = {bus_number, dev_number, func_number, err ? CPL_STATUS_UR : CPL_STATUS_SC,
                   1'b0, bytes};
        push_expect(b);
        b.data  = {id.reqid, id.tag, 1'b0, addr};
        b.last  = write || err;
        push_expect(b);
    endtask

    task automatic issue_write(input logic [1:0] resp);
        cpl_id_t id;
        id = rand_id(1'b1);
        id_q.push_back(id);
        wr_h_q.push_back(resp);
        expect_header(id, resp != OKAY, 10'd1, 12'd4, 7'd0, 1'b1);
    endtask

    // First part takes the given response, later parts answer OKAY
    task automatic issue_read(input int parts, input logic [1:0] first_resp);
        cpl_id_t     id;
        rd_hdr_t     h;
        logic        err;
        logic [31:0] r;
        int          beats;
        id  = rand_id(1'b0);
        err = 1'b0;
        id_q.push_back(id);
        for (int p = 0; p < parts; p++) begin
            r       = $random(seed);
            beats   = 1 + int'(r[2:0]);
            h.addr  = r[9:3];
            h.len   = 10'(beats);
            h.bytes = 12'(beats * 4);
            h.last  = (p == parts - 1);
            h.resp  = (p == 0) ? first_resp : OKAY;
            err     = err || (h.resp != OKAY);
            rd_h_q.push_back(h);
            expect_header(id, err, h.len, h.bytes, h.addr, 1'b0);
            for (int b = 0; b < beats; b++) begin
                r = $random(seed);
                rd_d_q.push_back({b == beats - 1, r});
                if (!err) begin
                    push_expect({1'b0, b == beats - 1, r});
                end
            end
        end
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_base = errors;
    endtask

    task automatic wait_drain();
        while (exp_q.size() > 0 || id_q.size() > 0 || rd_d_q.size() > 0 || tlp_id_valid
               || wr_h_valid || rd_h_valid || rd_d_valid) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    task automatic end_test();
        if (errors == err_base) begin
            pass_count++;
            $display("test %s passed", cur_test);
        end else begin
            fail_count++;
            $display("test %s failed with %0d errors", cur_test, errors - err_base);
        end
    endtask

    initial begin : stimulus
        logic [31:0] r;
        wait (!rst);
        @(posedge clk);

        begin_test("write_okay");
        issue_write(OKAY);
        wait_drain();
        end_test();

        begin_test("write_slverr");
        issue_write(SLVERR);
        wait_drain();
        end_test();

        begin_test("read_two_parts");
        issue_read(2, OKAY);
        wait_drain();
        end_test();

        begin_test("read_decerr_flush");
        issue_read(2, DECERR);
        wait_drain();
        end_test();

        begin_test("mixed_with_stalls");
        stall_en = 1'b1;
        repeat (12) begin
            r = $random(seed);
            case (r[1:0])
                2'd0:    issue_write(OKAY);
                2'd1:    issue_write(SLVERR);
                2'd2:    issue_read(int'(r[3:2]) % 3 + 1, OKAY);
                default: issue_read(int'(r[3:2]) % 3 + 1, DECERR);
            endcase
        end
        wait_drain();
        stall_en = 1'b0;
        end_test();

        // One ID more than the FIFO holds
        begin_test("np_backpressure");
        fill_check = 1'b1;
        id_base    = id_accepted;
        repeat (`CPL_ID_DEPTH + 1) begin
            r = $random(seed);
            issue_write(r[0] ? SLVERR : OKAY);
        end
        while (id_accepted - id_base < `CPL_ID_DEPTH) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        assert (!tlp_id_ready && !rx_np_ok) else begin
            $display("%s: ID FIFO full but still signals room", cur_test);
            errors++;
        end
        fill_check = 1'b0;
        wait_drain();
        assert (tlp_id_ready && rx_np_ok) else begin
            $display("%s: ID FIFO did not recover after the completions drained", cur_test);
            errors++;
        end
        end_test();

        $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Budget of 20 cycles per expected beat, with a margin for the ID fill
    initial begin : watchdog
        while (cycles <= (planned_beats + 50) * 20) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout in test %s after %0d cycles", cur_test, cycles);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire
